//--- mcp_pkg.sv
`default_nettype none

package mcp_pkg;

   localparam int ROM_DEPTH = 64;                        // Words in the microcode table

   typedef logic [$clog2(ROM_DEPTH)-1:0] uaddr_t;        // Microcode address
   typedef logic [21:0]                  uword_t;        // Microinstruction word
   typedef logic [2:0]                   alu_op_t;       // ALU function select

   // Microword field positions, top down
   localparam int UW_ALU_MSB  = 21;
   localparam int UW_ALU_LSB  = 19;
   localparam int UW_SRC_IMM  = 18;                      // Operand B from immediate
   localparam int UW_REG_WR   = 17;                      // Write ALU result back
   localparam int UW_EMIT     = 16;                      // Push ALU result to host
   localparam int UW_LAST     = 15;                      // End of microroutine
   localparam int UW_SEQ_NEXT = 14;                      // Branch to next_addr
   localparam int UW_NEXT_MSB = 13;
   localparam int UW_NEXT_LSB = 8;                       // Bits 7..0 are spare

   localparam alu_op_t ALU_PASS = 3'd0;                  // Operand B straight through
   localparam alu_op_t ALU_ADD  = 3'd1;
   localparam alu_op_t ALU_SUB  = 3'd2;
   localparam alu_op_t ALU_XOR  = 3'd3;
   localparam alu_op_t ALU_ROL1 = 3'd4;                  // Rotate register left by one

   // Microroutine entry points
   localparam uaddr_t ENT_LOAD = 6'd0;
   localparam uaddr_t ENT_ADD  = 6'd1;
   localparam uaddr_t ENT_SUB  = 6'd2;
   localparam uaddr_t ENT_XOR  = 6'd3;
   localparam uaddr_t ENT_SWAP = 6'd8;                   // Eight rotates and an emit follow

   // Four-phase microcycle, one-hot
   typedef enum logic [3:0]
   {
      PH_C1 = 4'b0001,
      PH_C2 = 4'b0010,
      PH_C3 = 4'b0100,
      PH_C4 = 4'b1000
   } phase_t;

endpackage

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

   localparam int NUM_REGS = 8;                          // General registers in the core

   typedef logic [2:0]                  opcode_t;        // Macro opcode
   typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;       // Register index
   typedef logic [15:0]                 word_t;          // Data word

   localparam opcode_t OP_LOAD = 3'd0;
   localparam opcode_t OP_ADD  = 3'd1;
   localparam opcode_t OP_SUB  = 3'd2;
   localparam opcode_t OP_XOR  = 3'd3;
   localparam opcode_t OP_SWAP = 3'd4;                   // Codes 5..7 run as LOAD

   localparam int INSTR_CREDITS = 2;                     // Core instruction buffer depth
   localparam int RES_CREDITS   = 4;                     // Host result buffer depth
   localparam int RQ_DEPTH      = 4;                     // Core result FIFO depth

   typedef logic [$clog2(RES_CREDITS+1)-1:0] credit_t;   // Result credit count

endpackage

`default_nettype wire

//--- micro_rom.sv
`default_nettype none
`timescale 1ns/1ps

module micro_rom
(
   input  wire              clk,
   input  wire              rst_n,
   input  wire mcp_pkg::phase_t phase,
   input  wire mcp_pkg::uaddr_t rom_addr,
   input  wire              rom_sel,                      // Low reads the no-op word
   output mcp_pkg::uword_t  uword
);

   mcp_pkg::uaddr_t addr_q;                               // Address taken in C2
   mcp_pkg::uword_t rom_word;                             // Array output

   // Pack the microword fields
   function automatic mcp_pkg::uword_t uw
   (
      mcp_pkg::alu_op_t op,
      logic             imm,
      logic             wr,
      logic             emit,
      logic             last,
      logic             seq,
      mcp_pkg::uaddr_t  nxt
   );
      return {op, imm, wr, emit, last, seq, nxt, 8'h00};
   endfunction

   // Microcode table
   always_comb
   begin
      case (addr_q) inside
         mcp_pkg::ENT_LOAD: rom_word = uw(mcp_pkg::ALU_PASS, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, '0);
         mcp_pkg::ENT_ADD:  rom_word = uw(mcp_pkg::ALU_ADD,  1'b1, 1'b1, 1'b1, 1'b1, 1'b0, '0);
         mcp_pkg::ENT_SUB:  rom_word = uw(mcp_pkg::ALU_SUB,  1'b1, 1'b1, 1'b1, 1'b1, 1'b0, '0);
         mcp_pkg::ENT_XOR:  rom_word = uw(mcp_pkg::ALU_XOR,  1'b1, 1'b1, 1'b1, 1'b1, 1'b0, '0);
         [mcp_pkg::ENT_SWAP : mcp_pkg::ENT_SWAP + 6'd7]:  // Rotate step, chain to next word
            rom_word = uw(mcp_pkg::ALU_ROL1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, addr_q + 6'd1);
         mcp_pkg::ENT_SWAP + 6'd8:                        // Emit the swapped register
            rom_word = uw(mcp_pkg::ALU_PASS, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, '0);
         default:           rom_word = '0;                // Unused words are no-ops
      endcase
   end

   // Address latch in C2, array read in C3, word held until the next read
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         addr_q <= '0;
         uword  <= '0;
      end
      else
      begin
         if (phase == mcp_pkg::PH_C2)
            addr_q <= rom_addr;
         if (phase == mcp_pkg::PH_C3)
            uword <= rom_sel ? rom_word : '0;             // Deselected chip gives no-op
      end
   end

endmodule

`default_nettype wire

//--- control_seq.sv
`default_nettype none
`timescale 1ns/1ps

module control_seq
(
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    instr_valid,
   input  wire bus_pkg::opcode_t  instr_op,
   input  wire bus_pkg::reg_idx_t instr_reg,
   input  wire bus_pkg::word_t    instr_imm,
   input  wire mcp_pkg::uword_t   uword,
   input  wire                    res_space,
   output logic                   instr_credit,
   output mcp_pkg::phase_t        phase,
   output mcp_pkg::uaddr_t        rom_addr,
   output logic                   rom_sel,
   output bus_pkg::reg_idx_t      cur_reg,
   output bus_pkg::word_t         cur_imm
);

   typedef enum logic {SEQ_IDLE, SEQ_RUN} seq_state_t;

   bus_pkg::opcode_t  buf_op  [bus_pkg::INSTR_CREDITS];   // Instruction buffer
   bus_pkg::reg_idx_t buf_reg [bus_pkg::INSTR_CREDITS];
   bus_pkg::word_t    buf_imm [bus_pkg::INSTR_CREDITS];
   logic [$clog2(bus_pkg::INSTR_CREDITS)-1:0]   buf_wr;
   logic [$clog2(bus_pkg::INSTR_CREDITS)-1:0]   buf_rd;
   logic [$clog2(bus_pkg::INSTR_CREDITS+1)-1:0] buf_cnt;

   seq_state_t      seq_state;
   mcp_pkg::phase_t phase_nxt;
   logic            stall;                                 // Emit with result FIFO full
   logic            c1_end;                                // C1 closes this clock
   logic            follow;                                // Branch within routine
   logic            rtn_end;                               // Routine done or idle
   logic            dispatch;                              // Start next instruction

   // Map a macro opcode to its microroutine
   function automatic mcp_pkg::uaddr_t entry_of(bus_pkg::opcode_t op);
      case (op)
         bus_pkg::OP_LOAD: return mcp_pkg::ENT_LOAD;
         bus_pkg::OP_ADD:  return mcp_pkg::ENT_ADD;
         bus_pkg::OP_SUB:  return mcp_pkg::ENT_SUB;
         bus_pkg::OP_XOR:  return mcp_pkg::ENT_XOR;
         bus_pkg::OP_SWAP: return mcp_pkg::ENT_SWAP;
         default:          return mcp_pkg::ENT_LOAD;
      endcase
   endfunction

   assign stall    = (phase == mcp_pkg::PH_C1) && uword[mcp_pkg::UW_EMIT] && !res_space;
   assign c1_end   = (phase == mcp_pkg::PH_C1) && !stall;
   assign follow   = c1_end && (seq_state == SEQ_RUN) && uword[mcp_pkg::UW_SEQ_NEXT];
   assign rtn_end  = c1_end && !follow && ((seq_state == SEQ_IDLE) || uword[mcp_pkg::UW_LAST]);
   assign dispatch = rtn_end && (buf_cnt != '0);
   assign rom_sel  = (seq_state == SEQ_RUN);               // ROM off while idle

   // Phase generator, frozen in C1 on stall
   always_comb
   begin
      case (phase)
         mcp_pkg::PH_C1: phase_nxt = stall ? mcp_pkg::PH_C1 : mcp_pkg::PH_C2;
         mcp_pkg::PH_C2: phase_nxt = mcp_pkg::PH_C3;
         mcp_pkg::PH_C3: phase_nxt = mcp_pkg::PH_C4;
         default:        phase_nxt = mcp_pkg::PH_C1;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         phase        <= mcp_pkg::PH_C1;
         seq_state    <= SEQ_IDLE;
         rom_addr     <= '0;
         instr_credit <= 1'b0;
         buf_wr       <= '0;
         buf_rd       <= '0;
         buf_cnt      <= '0;
      end
      else
      begin
         phase        <= phase_nxt;
         instr_credit <= dispatch;                         // Slot freed, credit back
         if (follow)
            rom_addr <= uword[mcp_pkg::UW_NEXT_MSB:mcp_pkg::UW_NEXT_LSB];
         else if (dispatch)
         begin
            rom_addr  <= entry_of(buf_op[buf_rd]);
            seq_state <= SEQ_RUN;
         end
         else if (rtn_end)
            seq_state <= SEQ_IDLE;                         // Nothing buffered
         if (instr_valid)
            buf_wr <= buf_wr + 1'b1;
         if (dispatch)
            buf_rd <= buf_rd + 1'b1;
         if (instr_valid && !dispatch)
            buf_cnt <= buf_cnt + 1'b1;
         else if (!instr_valid && dispatch)
            buf_cnt <= buf_cnt - 1'b1;
      end
   end

   // Buffer slots and current operands
   always_ff @(posedge clk)
   begin
      if (instr_valid)
      begin
         buf_op[buf_wr]  <= instr_op;
         buf_reg[buf_wr] <= instr_reg;
         buf_imm[buf_wr] <= instr_imm;
      end
      if (dispatch)
      begin
         cur_reg <= buf_reg[buf_rd];
         cur_imm <= buf_imm[buf_rd];
      end
   end

endmodule

`default_nettype wire

//--- data_path.sv
`default_nettype none
`timescale 1ns/1ps

module data_path
(
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire mcp_pkg::phase_t   phase,
   input  wire mcp_pkg::uword_t   uword,
   input  wire bus_pkg::reg_idx_t cur_reg,
   input  wire bus_pkg::word_t    cur_imm,
   output bus_pkg::word_t         alu_out
);

   bus_pkg::word_t   regs [bus_pkg::NUM_REGS];             // Register file
   bus_pkg::word_t   opnd_a;                               // Register operand, loaded in C4
   bus_pkg::word_t   opnd_b;                               // Immediate or register
   mcp_pkg::alu_op_t alu_op;
   logic             reg_we;

   assign alu_op = uword[mcp_pkg::UW_ALU_MSB:mcp_pkg::UW_ALU_LSB];
   assign opnd_b = uword[mcp_pkg::UW_SRC_IMM] ? cur_imm : opnd_a;

   // A stall repeats C1, so the result comes from the latched operand
   // and the same value is written again
   assign reg_we = (phase == mcp_pkg::PH_C1) && uword[mcp_pkg::UW_REG_WR];

   always_comb
   begin
      case (alu_op)
         mcp_pkg::ALU_ADD:  alu_out = opnd_a + opnd_b;     // Wraps at 16 bits
         mcp_pkg::ALU_SUB:  alu_out = opnd_a - opnd_b;
         mcp_pkg::ALU_XOR:  alu_out = opnd_a ^ opnd_b;
         mcp_pkg::ALU_ROL1: alu_out = {opnd_a[14:0], opnd_a[15]};
         default:           alu_out = opnd_b;              // PASS and spare codes
      endcase
   end

   // Operand latch, C4 is never stretched
   always_ff @(posedge clk)
   begin
      if (phase == mcp_pkg::PH_C4)
         opnd_a <= regs[cur_reg];
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < bus_pkg::NUM_REGS; i++)
            regs[i] <= '0;
      end
      else if (reg_we)
         regs[cur_reg] <= alu_out;                         // Write back at end of C1
   end

endmodule

`default_nettype wire

//--- result_queue.sv
`default_nettype none
`timescale 1ns/1ps

module result_queue
(
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire mcp_pkg::phase_t   phase,
   input  wire mcp_pkg::uword_t   uword,
   input  wire bus_pkg::word_t    alu_out,
   input  wire bus_pkg::reg_idx_t cur_reg,
   input  wire                    res_credit,
   output logic                   res_space,
   output logic                   res_valid,
   output bus_pkg::word_t         res_data,
   output bus_pkg::reg_idx_t      res_reg
);

   bus_pkg::word_t    q_data [bus_pkg::RQ_DEPTH];
   bus_pkg::reg_idx_t q_reg  [bus_pkg::RQ_DEPTH];
   logic [$clog2(bus_pkg::RQ_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(bus_pkg::RQ_DEPTH)-1:0]   rd_ptr;
   logic [$clog2(bus_pkg::RQ_DEPTH+1)-1:0] count;          // FIFO occupancy
   bus_pkg::credit_t                       credits;        // Free slots at host
   logic                                   push;
   logic                                   pop;

   assign res_space = (count < bus_pkg::RQ_DEPTH);
   assign push      = (phase == mcp_pkg::PH_C1) && uword[mcp_pkg::UW_EMIT] && res_space;
   assign pop       = (count != '0) && (credits != '0);     // One beat per clock

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         credits   <= bus_pkg::credit_t'(bus_pkg::RES_CREDITS);
         res_valid <= 1'b0;
      end
      else
      begin
         res_valid <= pop;
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (!push && pop)
            count <= count - 1'b1;
         if (res_credit && !pop)
            credits <= credits + 1'b1;                     // Host drained one
         else if (!res_credit && pop)
            credits <= credits - 1'b1;
      end
   end

   // Payload storage and output beat
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         q_data[wr_ptr] <= alu_out;
         q_reg[wr_ptr]  <= cur_reg;
      end
      if (pop)
      begin
         res_data <= q_data[rd_ptr];
         res_reg  <= q_reg[rd_ptr];
      end
   end

endmodule

`default_nettype wire

//--- lsi_core.sv
`default_nettype none
`timescale 1ns/1ps

module lsi_core
(
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    instr_valid,
   input  wire bus_pkg::opcode_t  instr_op,
   input  wire bus_pkg::reg_idx_t instr_reg,
   input  wire bus_pkg::word_t    instr_imm,
   output logic                   instr_credit,
   output logic                   res_valid,
   output bus_pkg::word_t         res_data,
   output bus_pkg::reg_idx_t      res_reg,
   input  wire                    res_credit
);

   mcp_pkg::phase_t   phase;                               // One-hot microcycle phase
   mcp_pkg::uaddr_t   rom_addr;
   logic              rom_sel;
   mcp_pkg::uword_t   uword;                               // Microinstruction bus
   bus_pkg::reg_idx_t cur_reg;
   bus_pkg::word_t    cur_imm;
   bus_pkg::word_t    alu_out;
   logic              res_space;

   control_seq control_seq_i
   (
      .clk(clk), .rst_n(rst_n),
      .instr_valid(instr_valid), .instr_op(instr_op),
      .instr_reg(instr_reg), .instr_imm(instr_imm),
      .uword(uword), .res_space(res_space), .instr_credit(instr_credit),
      .phase(phase), .rom_addr(rom_addr), .rom_sel(rom_sel),
      .cur_reg(cur_reg), .cur_imm(cur_imm)
   );

   micro_rom micro_rom_i
   (
      .clk(clk), .rst_n(rst_n), .phase(phase),
      .rom_addr(rom_addr), .rom_sel(rom_sel), .uword(uword)
   );

   data_path data_path_i
   (
      .clk(clk), .rst_n(rst_n), .phase(phase), .uword(uword),
      .cur_reg(cur_reg), .cur_imm(cur_imm), .alu_out(alu_out)
   );

   result_queue result_queue_i
   (
      .clk(clk), .rst_n(rst_n), .phase(phase), .uword(uword),
      .alu_out(alu_out), .cur_reg(cur_reg), .res_credit(res_credit),
      .res_space(res_space), .res_valid(res_valid),
      .res_data(res_data), .res_reg(res_reg)
   );

endmodule

`default_nettype wire

//--- lsi_core_props.sv
`default_nettype none
`timescale 1ns/1ps

module lsi_core_props
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire mcp_pkg::phase_t phase,
   input  wire mcp_pkg::uword_t uword,                    // Microinstruction bus
   input  wire                  seq_run,                  // Sequencer busy with a routine
   input  wire                  instr_valid,
   input  wire                  instr_credit,
   input  wire                  res_valid,
   input  wire                  res_credit
);

   int res_cred;                                          // Free slots at the host
   int instr_out;                                         // Instructions held by the core

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         res_cred  <= bus_pkg::RES_CREDITS;
         instr_out <= 0;
      end
      else
      begin
         res_cred  <= res_cred - int'(res_valid) + int'(res_credit);
         instr_out <= instr_out + int'(instr_valid) - int'(instr_credit);
      end
   end

   phase_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(phase))
      else $error("phase is not one-hot: %b", phase);

   // Beat counted at the host one edge after the core spent its credit
   res_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> (res_cred > 0))
      else $error("res_valid high with no result credit left");

   // Host never holds more credits than it started with
   instr_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      instr_out >= 0)
      else $error("core returned more instruction credits than it received");

   // Idle sequencer reads with the ROM deselected, so C4 sees the no-op word
   rom_off_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (!seq_run && phase == mcp_pkg::PH_C4) |-> (uword == '0))
      else $error("microword not cleared while the sequencer is idle");

endmodule

`default_nettype wire

//--- lsi_core_checker.sv
`default_nettype none
`timescale 1ns/1ps

module lsi_core_checker
(
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    instr_valid,
   input  wire bus_pkg::opcode_t  instr_op,
   input  wire bus_pkg::reg_idx_t instr_reg,
   input  wire bus_pkg::word_t    instr_imm,
   input  wire                    res_valid,
   input  wire bus_pkg::word_t    res_data,
   input  wire bus_pkg::reg_idx_t res_reg,
   output int                     n_checked,             // Result beats compared
   output int                     n_errors,
   output int                     n_left                 // Results still expected
);

   bus_pkg::word_t    model_regs [bus_pkg::NUM_REGS];    // Reference register file
   bus_pkg::word_t    exp_data   [$];                    // Expected results, in order
   bus_pkg::reg_idx_t exp_reg    [$];

   // Executes one macro-instruction on the model, returns 1 if it emits
   function automatic bit ref_exec
   (
      input  bus_pkg::opcode_t  op,
      input  bus_pkg::reg_idx_t r,
      input  bus_pkg::word_t    imm,
      output bus_pkg::word_t    val
   );
      bus_pkg::word_t cur;
      bit             emits;
      cur   = model_regs[r];
      emits = 1'b1;
      case (op)
         bus_pkg::OP_ADD:  val = cur + imm;              // Modulo 2^16
         bus_pkg::OP_SUB:  val = cur - imm;
         bus_pkg::OP_XOR:  val = cur ^ imm;
         bus_pkg::OP_SWAP: val = {cur[7:0], cur[15:8]};  // Bytes exchanged
         default:
         begin
            val   = imm;                                 // LOAD and unused codes
            emits = 1'b0;
         end
      endcase
      model_regs[r] = val;
      return emits;
   endfunction

   // Inputs are driven after the edge, so both sides are sampled stable here
   always @(posedge clk or negedge rst_n)
   begin
      bus_pkg::word_t    exp_v;
      bus_pkg::reg_idx_t exp_r;
      bus_pkg::word_t    new_v;
      if (!rst_n)
      begin
         for (int i = 0; i < bus_pkg::NUM_REGS; i++)
            model_regs[i] = '0;
         exp_data.delete();
         exp_reg.delete();
         n_checked = 0;
         n_errors  = 0;
      end
      else
      begin
         if (res_valid)
         begin
            if (exp_data.size() == 0)
            begin
               $display("Result beat with nothing outstanding, res_reg %h res_data %h",
                        res_reg, res_data);
               n_errors++;
            end
            else
            begin
               exp_v = exp_data.pop_front();
               exp_r = exp_reg.pop_front();
               n_checked++;
               if (res_data !== exp_v)
               begin
                  $display("CHECK FAILED res_data: expected %h, got %h", exp_v, res_data);
                  n_errors++;
               end
               if (res_reg !== exp_r)
               begin
                  $display("CHECK FAILED res_reg: expected %h, got %h", exp_r, res_reg);
                  n_errors++;
               end
            end
         end
         if (instr_valid)
         begin
            if (ref_exec(instr_op, instr_reg, instr_imm, new_v))
            begin
               exp_data.push_back(new_v);
               exp_reg.push_back(instr_reg);
            end
         end
      end
      n_left = exp_data.size();
   end

endmodule

`default_nettype wire

//--- tb_lsi_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_lsi_core;

   localparam int CLK_PERIOD = 40;
   localparam int LEN_RESET  = 2;                        // Instructions per test
   localparam int LEN_ALU    = 3 * bus_pkg::NUM_REGS;
   localparam int LEN_SWAP   = 7;
   localparam int LEN_HOLD   = 16;                       // Cap, the core stalls earlier
   localparam int LEN_MIX    = 200;
   localparam int WATCHDOG_CYCLES =
      (LEN_RESET + LEN_ALU + LEN_SWAP + LEN_HOLD + LEN_MIX) * 200 + 1000;

   logic              clk;
   logic              rst_n;
   logic              instr_valid;
   bus_pkg::opcode_t  instr_op;
   bus_pkg::reg_idx_t instr_reg;
   bus_pkg::word_t    instr_imm;
   logic              instr_credit;
   logic              res_valid;
   bus_pkg::word_t    res_data;
   bus_pkg::reg_idx_t res_reg;
   logic              res_credit = 1'b0;

   int n_sent       = 0;                                 // Instructions issued
   int n_cred_back  = 0;                                 // instr_credit pulses seen
   int n_res        = 0;                                 // Result beats seen
   int n_res_ret    = 0;                                 // Result credits given back
   int tb_errors    = 0;
   int n_tests      = 0;
   bit hold_credits = 1'b0;                              // Host stops consuming results
   int chk_checked;
   int chk_errors;
   int chk_left;

   lsi_core lsi_core_i
   (
      .clk(clk), .rst_n(rst_n),
      .instr_valid(instr_valid), .instr_op(instr_op),
      .instr_reg(instr_reg), .instr_imm(instr_imm), .instr_credit(instr_credit),
      .res_valid(res_valid), .res_data(res_data), .res_reg(res_reg),
      .res_credit(res_credit)
   );

   lsi_core_checker result_check_i
   (
      .clk(clk), .rst_n(rst_n),
      .instr_valid(instr_valid), .instr_op(instr_op),
      .instr_reg(instr_reg), .instr_imm(instr_imm),
      .res_valid(res_valid), .res_data(res_data), .res_reg(res_reg),
      .n_checked(chk_checked), .n_errors(chk_errors), .n_left(chk_left)
   );

   bind lsi_core lsi_core_props props_i
   (
      .clk(clk), .rst_n(rst_n), .phase(phase), .uword(uword),
      .seq_run(control_seq_i.seq_state),
      .instr_valid(instr_valid), .instr_credit(instr_credit),
      .res_valid(res_valid), .res_credit(res_credit)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Credit and beat counters, sampled at the edge
   always @(posedge clk)
   begin
      if (rst_n && instr_credit)
         n_cred_back++;
      if (rst_n && res_valid)
         n_res++;
   end

   // Host consumes buffered results at random moments
   always @(posedge clk)
   begin
      #2;
      if (rst_n && !hold_credits && n_res_ret < n_res && $urandom_range(3) != 0)
      begin
         res_credit = 1'b1;
         n_res_ret++;
      end
      else
         res_credit = 1'b0;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   function automatic int host_credits();
      return bus_pkg::INSTR_CREDITS - n_sent + n_cred_back;
   endfunction

   function automatic int total_errors();
      return chk_errors + tb_errors;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #2;                                                // Drive point after the edge
   endtask

   task automatic send_instr
   (
      input bus_pkg::opcode_t  op,
      input bus_pkg::reg_idx_t r,
      input bus_pkg::word_t    imm
   );
      repeat ($urandom_range(2)) next_cycle();           // Random gap
      while (host_credits() == 0)
         next_cycle();
      instr_valid = 1'b1;
      instr_op    = op;
      instr_reg   = r;
      instr_imm   = imm;
      n_sent++;
      next_cycle();
      instr_valid = 1'b0;
   endtask

   // All dispatched, all results in and consumed by the host
   task automatic drain(input int limit);
      int cyc;
      cyc = 0;
      while ((chk_left != 0 || n_sent != n_cred_back || n_res_ret != n_res) && cyc < limit)
      begin
         next_cycle();
         cyc++;
      end
      if (cyc >= limit)
      begin
         $display("Results did not drain within %0d cycles, %0d still expected", limit, chk_left);
         tb_errors++;
      end
   endtask

   task automatic end_test(input string name, input int err_before);
      n_tests++;
      $display("Test %0d %s finished with %0d errors", n_tests, name,
               total_errors() - err_before);
   endtask

   initial
   begin
      int err0;
      int res0;
      int n4;
      int idle;
      void'($urandom(32'hda73_29ef));
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr_op    = '0;
      instr_reg   = '0;
      instr_imm   = '0;
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // Quiet after reset, LOAD is silent, ADD 0 reads it back
      err0 = total_errors();
      repeat (20)
      begin
         next_cycle();
         if (res_valid || instr_credit)
         begin
            $display("res_valid or instr_credit went high with no instruction sent");
            tb_errors++;
         end
      end
      res0 = n_res;
      send_instr(bus_pkg::OP_LOAD, 3'd3, 16'hbeef);
      drain(400);
      repeat (16) next_cycle();                          // Room for a stray result
      if (n_res != res0)
      begin
         $display("LOAD produced a result beat");
         tb_errors++;
      end
      send_instr(bus_pkg::OP_ADD, 3'd3, 16'h0000);
      drain(400);
      if (n_res != res0 + 1)
      begin
         $display("ADD after LOAD gave %0d result beats instead of one", n_res - res0);
         tb_errors++;
      end
      end_test("reset_and_load", err0);

      // Every ALU op on every register
      err0 = total_errors();
      for (int r = 0; r < bus_pkg::NUM_REGS; r++)
      begin
         send_instr(bus_pkg::OP_ADD, bus_pkg::reg_idx_t'(r), bus_pkg::word_t'($urandom()));
         send_instr(bus_pkg::OP_SUB, bus_pkg::reg_idx_t'(r), bus_pkg::word_t'($urandom()));
         send_instr(bus_pkg::OP_XOR, bus_pkg::reg_idx_t'(r), bus_pkg::word_t'($urandom()));
      end
      drain(LEN_ALU * 200);
      end_test("alu_all_regs", err0);

      // SWAP result stays in the register
      err0 = total_errors();
      send_instr(bus_pkg::OP_LOAD, 3'd5, 16'h12ab);
      send_instr(bus_pkg::OP_SWAP, 3'd5, 16'h0000);
      send_instr(bus_pkg::OP_ADD,  3'd5, 16'h0000);
      send_instr(bus_pkg::OP_SWAP, 3'd5, 16'hffff);      // Immediate ignored
      send_instr(bus_pkg::OP_XOR,  3'd5, 16'h00ff);
      send_instr(bus_pkg::OP_LOAD, 3'd0, bus_pkg::word_t'($urandom()));
      send_instr(bus_pkg::OP_SWAP, 3'd0, 16'h0000);
      drain(LEN_SWAP * 200);
      end_test("swap_bytes", err0);

      // Withhold result credits until the core stops taking instructions
      err0 = total_errors();
      res0 = n_res;
      hold_credits = 1'b1;
      n4   = 0;
      idle = 0;
      while (idle < 200 && n4 < LEN_HOLD)
      begin
         if (host_credits() > 0)
         begin
            send_instr(bus_pkg::OP_ADD, bus_pkg::reg_idx_t'($urandom_range(7)),
                       bus_pkg::word_t'($urandom()));
            n4++;
            idle = 0;
         end
         else
         begin
            next_cycle();
            idle++;
         end
      end
      if (n_res - res0 > bus_pkg::RES_CREDITS)
      begin
         $display("%0d results arrived with only %0d result credits", n_res - res0,
                  bus_pkg::RES_CREDITS);
         tb_errors++;
      end
      if (n4 >= LEN_HOLD || host_credits() != 0)
      begin
         $display("Core kept returning instruction credits while results were held");
         tb_errors++;
      end
      hold_credits = 1'b0;
      drain(LEN_HOLD * 200);
      end_test("result_backpressure", err0);

      // Random stream, codes 5 to 7 included
      err0 = total_errors();
      repeat (LEN_MIX)
         send_instr(bus_pkg::opcode_t'($urandom_range(7)), bus_pkg::reg_idx_t'($urandom_range(7)),
                    bus_pkg::word_t'($urandom()));
      drain(LEN_MIX * 200);
      end_test("random_mix", err0);

      $display("Tests run %0d, results checked %0d, errors %0d", n_tests, chk_checked,
               total_errors());
      if (total_errors() == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
mcp_pkg.sv
bus_pkg.sv
micro_rom.sv
control_seq.sv
data_path.sv
result_queue.sv
lsi_core.sv
lsi_core_props.sv
lsi_core_checker.sv
tb_lsi_core.sv
